//--- design/dumpPkg.sv
package dumpPkg;

    // Bit timing for a 27 MHz clock at 115200 baud.
    localparam int clocksPerBit = 234;

    // Quiet time on the line after the last stop bit of a dump.
    localparam int holdoffCycles = 4096;

    localparam int bytesPerWord = 4;

    // Wide enough to count up to holdoffCycles - 1.
    localparam int timerWidth = 13;

    localparam logic [2:0] stateIdle = 3'd0;
    localparam logic [2:0] stateStart = 3'd1;
    localparam logic [2:0] stateData = 3'd2;
    localparam logic [2:0] stateStop = 3'd3;
    localparam logic [2:0] stateHoldoff = 3'd4;

    // The dump word seen either whole or as bytes.
    // Byte 3 is the most significant byte and is sent first.
    typedef union packed {
        logic [31:0] word;
        logic [bytesPerWord-1:0][7:0] bytes;
    } dumpWord_t;

endpackage

//--- design/dumpController.sv
`timescale 1ns/10ps

module dumpController (
    input  logic       clk,
    input  logic       reset,
    input  logic       dumpButton,
    input  logic       bitEnd,
    input  logic       holdoffEnd,
    output logic       timerClear,
    output logic       holdoffPhase,
    output logic       captureWord,
    output logic       loadFrame,
    output logic [1:0] byteIndex,
    output logic       shiftBit,
    output logic       dumpBusy
);
    import dumpPkg::*;

    logic [2:0] state;
    logic [2:0] nextState;
    logic [2:0] bitCount;  // Data bit currently on the line.
    logic [1:0] byteCount; // Byte currently in the frame register.
    logic       pressed;
    logic       lastByte;
    logic       leaving;

    assign pressed = ~dumpButton; // The button is active low.
    assign lastByte = (byteCount == 2'd0);
    assign holdoffPhase = (state == stateHoldoff);
    assign leaving = (state == stateHoldoff) && (nextState == stateIdle);

    always_comb begin
        nextState = state;
        timerClear = 1'b0;
        captureWord = 1'b0;
        loadFrame = 1'b0;
        shiftBit = 1'b0;
        byteIndex = byteCount - 2'd1;
        case (state)
            stateIdle: begin
                // Keep the timer at zero so the first start bit has its full length.
                timerClear = 1'b1;
                byteIndex = 2'(bytesPerWord - 1);
                if (pressed) begin
                    nextState = stateStart;
                    captureWord = 1'b1;
                    loadFrame = 1'b1;
                end
            end
            stateStart: begin
                shiftBit = bitEnd;
                if (bitEnd) begin
                    nextState = stateData;
                end
            end
            stateData: begin
                shiftBit = bitEnd;
                if (bitEnd && bitCount == 3'd7) begin
                    nextState = stateStop;
                end
            end
            stateStop: begin
                if (bitEnd) begin
                    if (lastByte) begin
                        nextState = stateHoldoff;
                        timerClear = 1'b1; // The hold-off count starts here.
                    end else begin
                        nextState = stateStart;
                        loadFrame = 1'b1;
                    end
                end
            end
            stateHoldoff: begin
                // A button still held from the press keeps the port parked here.
                if (holdoffEnd && !pressed) begin
                    nextState = stateIdle;
                end
            end
            default: begin
                nextState = stateIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stateIdle;
            bitCount <= '0;
            byteCount <= '0;
            dumpBusy <= 1'b0;
        end else begin
            state <= nextState;

            if (state == stateIdle) begin
                byteCount <= 2'(bytesPerWord - 1);
            end else if (state == stateStop && bitEnd && !lastByte) begin
                byteCount <= byteCount - 2'd1;
            end

            if (state == stateStart) begin
                bitCount <= '0;
            end else if (state == stateData && bitEnd) begin
                bitCount <= bitCount + 3'd1;
            end

            // Rises together with the first start bit on the line.
            if (leaving) begin
                dumpBusy <= 1'b0;
            end else if (state != stateIdle) begin
                dumpBusy <= 1'b1;
            end
        end
    end

endmodule

//--- design/bitTimer.sv
`timescale 1ns/10ps

module bitTimer (
    input  logic clk,
    input  logic reset,
    input  logic timerClear,
    input  logic holdoffPhase,
    output logic bitEnd,
    output logic holdoffEnd
);
    import dumpPkg::*;

    logic [timerWidth-1:0] count;
    logic                  atBitLast;
    logic                  atHoldoffLast;

    assign atBitLast = (count == timerWidth'(clocksPerBit - 1));
    assign atHoldoffLast = (count == timerWidth'(holdoffCycles - 1));

    // Bit periods only matter while frames are being sent.
    assign bitEnd = atBitLast && !holdoffPhase;

    always_ff @(posedge clk) begin
        if (reset || timerClear) begin
            count <= '0;
        end else if (!holdoffPhase) begin
            if (atBitLast) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end else if (!atHoldoffLast) begin
            count <= count + 1'b1; // Stops at the last hold-off cycle.
        end
    end

    // Sticky until the controller clears the timer again.
    always_ff @(posedge clk) begin
        if (reset || timerClear) begin
            holdoffEnd <= 1'b0;
        end else if (holdoffPhase && atHoldoffLast) begin
            holdoffEnd <= 1'b1;
        end
    end

endmodule

//--- design/frameShifter.sv
`timescale 1ns/10ps

module frameShifter (
    input  logic               clk,
    input  logic               reset,
    input  dumpPkg::dumpWord_t dumpWord,
    input  logic               captureWord,
    input  logic               loadFrame,
    input  logic [1:0]         byteIndex,
    input  logic               shiftBit,
    output logic               uartTx
);
    import dumpPkg::*;

    dumpWord_t  heldWord;
    dumpWord_t  loadSource;
    logic [9:0] frame; // Stop bit, eight data bits, start bit in the low position.

    // The first frame of a dump is built from the live word on the capture edge.
    assign loadSource = captureWord ? dumpWord : heldWord;

    always_ff @(posedge clk) begin
        if (captureWord) begin
            heldWord <= dumpWord;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            frame <= '1;
        end else if (loadFrame) begin
            frame <= {1'b1, loadSource.bytes[byteIndex], 1'b0};
        end else if (shiftBit) begin
            frame <= {1'b1, frame[9:1]}; // Ones fill in behind, so the line idles high.
        end
    end

    // Registered line output.
    always_ff @(posedge clk) begin
        if (reset) begin
            uartTx <= 1'b1;
        end else begin
            uartTx <= frame[0];
        end
    end

endmodule

//--- design/uartDump.sv
`timescale 1ns/10ps

module uartDump (
    input  logic               clk,
    input  logic               reset,
    input  logic               dumpButton,
    input  dumpPkg::dumpWord_t dumpWord,
    output logic               uartTx,
    output logic               dumpBusy
);

    logic       timerClear;
    logic       holdoffPhase;
    logic       bitEnd;
    logic       holdoffEnd;
    logic       captureWord;
    logic       loadFrame;
    logic [1:0] byteIndex;
    logic       shiftBit;

    dumpController controller (
        .clk         (clk),
        .reset       (reset),
        .dumpButton  (dumpButton),
        .bitEnd      (bitEnd),
        .holdoffEnd  (holdoffEnd),
        .timerClear  (timerClear),
        .holdoffPhase(holdoffPhase),
        .captureWord (captureWord),
        .loadFrame   (loadFrame),
        .byteIndex   (byteIndex),
        .shiftBit    (shiftBit),
        .dumpBusy    (dumpBusy)
    );

    bitTimer timer (
        .clk         (clk),
        .reset       (reset),
        .timerClear  (timerClear),
        .holdoffPhase(holdoffPhase),
        .bitEnd      (bitEnd),
        .holdoffEnd  (holdoffEnd)
    );

    frameShifter shifter (
        .clk        (clk),
        .reset      (reset),
        .dumpWord   (dumpWord),
        .captureWord(captureWord),
        .loadFrame  (loadFrame),
        .byteIndex  (byteIndex),
        .shiftBit   (shiftBit),
        .uartTx     (uartTx)
    );

endmodule

//--- test/uartDump_props.sv
`timescale 1ns/10ps

module uartDumpProps (
    input logic       clk,
    input logic       reset,
    input logic       dumpButton,
    input logic       uartTx,
    input logic       dumpBusy,
    input logic [2:0] state
);
    import dumpPkg::*;

    int unsigned busyCycles; // Cycles since dumpBusy rose.
    int unsigned failCount = 0;

    always_ff @(posedge clk) begin
        if (reset || !dumpBusy) begin
            busyCycles <= 0;
        end else begin
            busyCycles <= busyCycles + 1;
        end
    end

    property lineHighWhenIdle;
        @(posedge clk) disable iff (reset) !dumpBusy |-> uartTx;
    endproperty

    // Near idle a low line can only be a start bit that follows a press.
    property startOnlyAfterPress;
        @(posedge clk) disable iff (reset)
            (state == stateIdle || $past(state) == stateIdle) && !uartTx |-> $past(!dumpButton);
    endproperty

    property busyCoversHoldoff;
        @(posedge clk) disable iff (reset) $fell(dumpBusy) |-> busyCycles >= holdoffCycles;
    endproperty

    assert property (lineHighWhenIdle) else begin
        $error("uartTx low while dumpBusy is low");
        failCount++;
    end

    assert property (startOnlyAfterPress) else begin
        $error("uartTx low near idle without a press");
        failCount++;
    end

    assert property (busyCoversHoldoff) else begin
        $error("dumpBusy fell before the hold-off ended");
        failCount++;
    end

endmodule

bind uartDump uartDumpProps props (
    .clk       (clk),
    .reset     (reset),
    .dumpButton(dumpButton),
    .uartTx    (uartTx),
    .dumpBusy  (dumpBusy),
    .state     (controller.state)
);

//--- test/uartDumpTb.sv
`timescale 1ns/10ps

module uartDumpTb;
    import dumpPkg::*;

    localparam int frameBits = 10;
    localparam int dumpCycles = bytesPerWord * frameBits * clocksPerBit + holdoffCycles;
    localparam int timeoutCycles = 11 * dumpCycles + 2000; // Ten dumps plus a held hold-off.
    localparam int restOfStop = clocksPerBit - clocksPerBit / 2;

    logic      clk;
    logic      reset;
    logic      dumpButton;
    dumpWord_t dumpWord;
    logic      uartTx;
    logic      dumpBusy;

    int cycleCount;
    int errorCount;
    int testErrorBase;
    int testsRun;
    int testsFailed;

    uartDump dut (
        .clk       (clk),
        .reset     (reset),
        .dumpButton(dumpButton),
        .dumpWord  (dumpWord),
        .uartTx    (uartTx),
        .dumpBusy  (dumpBusy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, the DUT never finished the running test.", cycleCount);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic compareWord(input string name, input dumpWord_t got, input dumpWord_t expected);
        int k;
        for (k = bytesPerWord - 1; k >= 0; k--) begin
            if (got.bytes[k] !== expected.bytes[k]) begin
                $display("FAIL %s byte %0d: got 0x%02h, expected 0x%02h",
                         name, k, got.bytes[k], expected.bytes[k]);
                errorCount++;
            end
        end
    endtask

    task automatic compareBit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
            errorCount++;
        end
    endtask

    task automatic compareCycles(input string name, input int got, input int low, input int high);
        if (got < low || got > high) begin
            $display("FAIL %s: got 0x%0h cycles, expected 0x%0h to 0x%0h", name, got, low, high);
            errorCount++;
        end
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (errorCount != testErrorBase) begin
            testsFailed++;
            $display("Test %s failed with %0d errors", name, errorCount - testErrorBase);
        end else begin
            $display("Test %s passed", name);
        end
    endtask

    task automatic pressAndRelease(input dumpWord_t word, input int holdCycles);
        @(posedge clk);
        dumpWord <= word;
        dumpButton <= 1'b0;
        repeat (holdCycles) @(posedge clk);
        dumpButton <= 1'b1;
    endtask

    task automatic pulseButton(input int delayCycles);
        repeat (delayCycles) @(posedge clk);
        dumpButton <= 1'b0;
        repeat (3) @(posedge clk);
        dumpButton <= 1'b1;
    endtask

    // Samples the line in the middle of every bit, counted from the edge where dumpBusy rose.
    task automatic receiveDump(output dumpWord_t got, output logic [3:0] startBits,
                               output logic [3:0] stopBits);
        logic [frameBits-1:0] bits;
        int k;
        int j;
        got = '0;
        @(negedge clk);
        while (dumpBusy !== 1'b1) begin
            @(negedge clk);
        end
        repeat (clocksPerBit / 2) @(negedge clk);
        for (k = 0; k < bytesPerWord; k++) begin
            for (j = 0; j < frameBits; j++) begin
                if (k != 0 || j != 0) begin
                    repeat (clocksPerBit) @(negedge clk);
                end
                bits[j] = uartTx;
            end
            startBits[k] = bits[0];
            stopBits[k] = bits[frameBits-1];
            got.bytes[bytesPerWord-1-k] = bits[8:1]; // Most significant byte comes first.
        end
    endtask

    task automatic checkFrames(input dumpWord_t got, input dumpWord_t expected,
                               input logic [3:0] startBits, input logic [3:0] stopBits);
        int k;
        compareWord("uartTx word", got, expected);
        for (k = 0; k < bytesPerWord; k++) begin
            compareBit($sformatf("uartTx start bit of frame %0d", k), startBits[k], 1'b0);
            compareBit($sformatf("uartTx stop bit of frame %0d", k), stopBits[k], 1'b1);
        end
    endtask

    // Counts cycles from the middle of the last stop bit until dumpBusy falls.
    task automatic checkHoldoff();
        int busyCycles;
        busyCycles = 0;
        while (dumpBusy === 1'b1) begin
            @(negedge clk);
            busyCycles++;
        end
        compareCycles("dumpBusy after last stop bit", busyCycles,
                      restOfStop + holdoffCycles, restOfStop + holdoffCycles + 2);
    endtask

    task automatic checkSteady(input string what, input logic busyLevel, input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(negedge clk);
            if (uartTx !== 1'b1 || dumpBusy !== busyLevel) begin
                compareBit({"uartTx ", what}, uartTx, 1'b1);
                compareBit({"dumpBusy ", what}, dumpBusy, busyLevel);
                break;
            end
        end
    endtask

    task automatic runDump(input dumpWord_t word);
        dumpWord_t  got;
        logic [3:0] startBits;
        logic [3:0] stopBits;
        fork
            pressAndRelease(word, 4);
            receiveDump(got, startBits, stopBits);
        join
        checkFrames(got, word, startBits, stopBits);
        checkHoldoff();
    endtask

    task automatic testResetState();
        testErrorBase = errorCount;
        checkSteady("after reset", 1'b0, 100);
        finishTest("reset state");
    endtask

    task automatic testSingleDump();
        dumpWord_t word;
        testErrorBase = errorCount;
        word.word = 32'hF9B99B9F;
        runDump(word);
        finishTest("single dump");
    endtask

    task automatic testCaptureAtPress();
        dumpWord_t  word;
        dumpWord_t  got;
        logic [3:0] startBits;
        logic [3:0] stopBits;
        testErrorBase = errorCount;
        word.word = 32'h1234ABCD;
        fork
            pressAndRelease(word, 4);
            receiveDump(got, startBits, stopBits);
            begin
                @(posedge clk);
                @(posedge clk); // The edge where the press is sampled.
                dumpWord <= ~word;
                repeat (5000) @(posedge clk);
                dumpWord <= 32'h00000000;
            end
        join
        checkFrames(got, word, startBits, stopBits);
        checkHoldoff();
        finishTest("capture at press");
    endtask

    task automatic testHoldoffRelease();
        dumpWord_t  word;
        dumpWord_t  got;
        logic [3:0] startBits;
        logic [3:0] stopBits;
        int         busyCycles;
        testErrorBase = errorCount;
        word.word = 32'h3C5A96E1;
        fork
            begin
                @(posedge clk);
                dumpWord <= word;
                dumpButton <= 1'b0; // Held low through the whole dump and hold-off.
            end
            receiveDump(got, startBits, stopBits);
        join
        checkFrames(got, word, startBits, stopBits);
        checkSteady("with button held", 1'b1, restOfStop + holdoffCycles + 200);
        @(posedge clk);
        dumpButton <= 1'b1;
        busyCycles = 0;
        while (dumpBusy === 1'b1) begin
            @(negedge clk);
            busyCycles++;
        end
        compareCycles("dumpBusy after release", busyCycles, 1, 3);
        word.word = 32'hA55A0FF0;
        runDump(word);
        finishTest("hold-off and release");
    endtask

    task automatic testIgnoredPresses();
        dumpWord_t  word;
        dumpWord_t  got;
        logic [3:0] startBits;
        logic [3:0] stopBits;
        testErrorBase = errorCount;
        word.word = 32'h80C3E17E;
        fork
            pressAndRelease(word, 3);
            receiveDump(got, startBits, stopBits);
            begin
                pulseButton(2000);
                pulseButton(4000);
            end
        join
        checkFrames(got, word, startBits, stopBits);
        fork
            pulseButton(1000); // Lands inside the hold-off.
            checkHoldoff();
        join
        checkSteady("after ignored presses", 1'b0, 3 * clocksPerBit);
        finishTest("ignored presses");
    endtask

    task automatic testRandomWords();
        dumpWord_t word;
        int        n;
        testErrorBase = errorCount;
        for (n = 0; n < 5; n++) begin
            word.word = $urandom();
            runDump(word);
        end
        finishTest("random words");
    endtask

    initial begin
        void'($urandom(32'h29b61771));
        reset = 1'b1;
        dumpButton = 1'b1;
        dumpWord = '0;
        errorCount = 0;
        testErrorBase = 0;
        testsRun = 0;
        testsFailed = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        testResetState();
        testSingleDump();
        testCaptureAtPress();
        testHoldoffRelease();
        testIgnoredPresses();
        testRandomWords();

        $display("Tests run %0d, tests failed %0d, checks failed %0d, assertions failed %0d",
                 testsRun, testsFailed, errorCount, dut.props.failCount);
        if (errorCount == 0 && dut.props.failCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
design/dumpPkg.sv
design/dumpController.sv
design/bitTimer.sv
design/frameShifter.sv
design/uartDump.sv
test/uartDump_props.sv
test/uartDumpTb.sv
